// ==== common/sha256_pkg.sv ====
//----------------------------------------------------------------------
// Shared SHA-256 types, round constants and bit functions for the
// pipelined compression core. Reference by scoped name, for example
// sha256_pkg::word_t or sha256_pkg::ch(e, f, g).
//----------------------------------------------------------------------
package sha256_pkg;

	typedef logic [31:0]  word_t;
	// Word 0 in the top bits
	typedef logic [511:0] block_t;
	// Working variables a..h, a in the top bits
	typedef logic [255:0] state_t;

	localparam int unsigned NUM_ROUNDS   = 64;
	localparam int unsigned WINDOW_WORDS = 16;

	// FIPS 180-4 round constants
	localparam word_t ROUND_K [0:NUM_ROUNDS-1] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	function automatic word_t rotr(input word_t x, input int unsigned n);
		return (x >> n) | (x << ($bits(word_t) - n));
	endfunction

	// Round functions
	function automatic word_t big_sigma0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t big_sigma1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	// Schedule functions
	function automatic word_t small_sigma0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t small_sigma1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	function automatic word_t ch(input word_t x, input word_t y, input word_t z);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic word_t maj(input word_t x, input word_t y, input word_t z);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

endpackage

// ==== msg_schedule/sha256_msg_schedule.sv ====
//----------------------------------------------------------------------
// Message-schedule pipeline. Stage s holds the sixteen-word window
// W(s+1)..W(s+16) and hands its oldest word to round stage s+1.
// All stages advance together on en_i, in lockstep with the rounds.
//----------------------------------------------------------------------
module sha256_msg_schedule (
	input  logic               CLK,
	input  logic               RST,
	input  logic               en_i,
	input  sha256_pkg::block_t block_i,
	output sha256_pkg::word_t  sched_words_o [0:sha256_pkg::NUM_ROUNDS-2]
);

	genvar s, j;

	generate
		for (s = 0; s < sha256_pkg::NUM_ROUNDS - 1; s++) begin : g_stage
			sha256_pkg::word_t src [0:sha256_pkg::WINDOW_WORDS-1];
			sha256_pkg::word_t win_q [0:sha256_pkg::WINDOW_WORDS-1];
			sha256_pkg::word_t new_word;

			// Window feeding this stage, oldest word at index 0
			for (j = 0; j < sha256_pkg::WINDOW_WORDS; j++) begin : g_src
				if (s == 0) begin : g_load
					assign src[j] = block_i[(sha256_pkg::WINDOW_WORDS - 1 - j) *
						$bits(sha256_pkg::word_t) +: $bits(sha256_pkg::word_t)];
				end else begin : g_chain
					assign src[j] = g_stage[s-1].win_q[j];
				end
			end

			// W(n) from W(n-2), W(n-7), W(n-15) and W(n-16)
			assign new_word = sha256_pkg::small_sigma1(src[14]) + src[9] +
				sha256_pkg::small_sigma0(src[1]) + src[0];

			always_ff @(posedge CLK or negedge RST) begin
				if (!RST) begin
					win_q <= '{default: '0};
				end else if (en_i) begin
					for (int k = 0; k < sha256_pkg::WINDOW_WORDS - 1; k++) begin
						win_q[k] <= src[k+1];
					end
					win_q[sha256_pkg::WINDOW_WORDS-1] <= new_word;
				end
			end

			// Later words of the last stages are never read and get trimmed
			assign sched_words_o[s] = win_q[0];
		end
	endgenerate

endmodule

// ==== round_pipe/sha256_round_pipe.sv ====
//----------------------------------------------------------------------
// Compression-round pipeline, one SHA-256 round per stage. Stage 0
// starts from the chaining value and word 0 of the block; stage t
// takes schedule word W(t). A valid bit follows each item through.
//----------------------------------------------------------------------
module sha256_round_pipe (
	input  logic               CLK,
	input  logic               RST,
	input  logic               en_i,
	input  logic               block_valid_i,
	input  sha256_pkg::word_t  first_word_i,
	input  sha256_pkg::state_t chain_i,
	input  sha256_pkg::word_t  sched_words_i [0:sha256_pkg::NUM_ROUNDS-2],
	output sha256_pkg::state_t final_state_o,
	output logic               final_valid_o
);

	logic [sha256_pkg::NUM_ROUNDS-1:0] valid_q;

	genvar t;

	function automatic sha256_pkg::state_t round_step(
		input sha256_pkg::state_t s,
		input sha256_pkg::word_t  k,
		input sha256_pkg::word_t  w
	);
		sha256_pkg::word_t a;
		sha256_pkg::word_t b;
		sha256_pkg::word_t c;
		sha256_pkg::word_t d;
		sha256_pkg::word_t e;
		sha256_pkg::word_t f;
		sha256_pkg::word_t g;
		sha256_pkg::word_t h;
		sha256_pkg::word_t t1;
		sha256_pkg::word_t t2;

		{a, b, c, d, e, f, g, h} = s;
		t1 = h + sha256_pkg::big_sigma1(e) + sha256_pkg::ch(e, f, g) + k + w;
		t2 = sha256_pkg::big_sigma0(a) + sha256_pkg::maj(a, b, c);
		return {t1 + t2, a, b, c, d + t1, e, f, g};
	endfunction

	generate
		for (t = 0; t < sha256_pkg::NUM_ROUNDS; t++) begin : g_round
			sha256_pkg::state_t state_in;
			sha256_pkg::word_t  word_in;
			sha256_pkg::state_t state_q;

			if (t == 0) begin : g_first
				assign state_in = chain_i;
				assign word_in  = first_word_i;
			end else begin : g_next
				assign state_in = g_round[t-1].state_q;
				assign word_in  = sched_words_i[t-1];
			end

			always_ff @(posedge CLK) begin
				if (en_i) begin
					state_q <= round_step(state_in, sha256_pkg::ROUND_K[t], word_in);
				end
			end
		end
	endgenerate

	// Valid bits shift alongside the states
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			valid_q <= '0;
		end else if (en_i) begin
			valid_q <= {valid_q[sha256_pkg::NUM_ROUNDS-2:0], block_valid_i};
		end
	end

	assign final_state_o = g_round[sha256_pkg::NUM_ROUNDS-1].state_q;
	assign final_valid_o = valid_q[sha256_pkg::NUM_ROUNDS-1];

endmodule

// ==== sources.f ====
common/sha256_pkg.sv
msg_schedule/sha256_msg_schedule.sv
round_pipe/sha256_round_pipe.sv
verilog/sha256_digest_add.sv
verilog/sha256_pipe_top.sv
tests/sha256_pipe_properties.sv
tests/sha256_pipe_tb.sv

// ==== tests/sha256_pipe_properties.sv ====
//----------------------------------------------------------------------
// Concurrent assertions on the SHA-256 core outputs. Bound to the
// top level below, so no testbench instance is needed.
//----------------------------------------------------------------------
module sha256_pipe_properties (
	input logic               CLK,
	input logic               RST,
	input logic               en_i,
	input sha256_pkg::state_t digest_o,
	input logic               digest_valid_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// Enabled edges since reset, saturating at the pipeline depth
	int unsigned en_edges;

	always @(posedge CLK or negedge RST) begin
		if (!RST) begin
			en_edges <= 0;
		end else if (en_i && en_edges < sha256_pkg::NUM_ROUNDS + 1) begin
			en_edges <= en_edges + 1;
		end
	end

	valid_low_in_reset: assert property (@(posedge CLK) !RST |-> !digest_valid_o)
		else $error("digest_valid_o high during reset");

	hold_on_stall: assert property (@(posedge CLK) disable iff (!RST)
		!en_i |=> $stable(digest_o) && $stable(digest_valid_o))
		else $error("outputs changed across a stalled edge");

	no_early_valid: assert property (@(posedge CLK) disable iff (!RST)
		$rose(digest_valid_o) |-> en_edges >= sha256_pkg::NUM_ROUNDS + 1)
		else $error("digest_valid_o rose before the pipeline could fill");

endmodule

bind sha256_pipe_top sha256_pipe_properties u_properties (
	.CLK            (CLK),
	.RST            (RST),
	.en_i           (en_i),
	.digest_o       (digest_o),
	.digest_valid_o (digest_valid_o)
);

// ==== tests/sha256_pipe_tb.sv ====
//----------------------------------------------------------------------
// Testbench for the pipelined SHA-256 core. Drives the known "abc"
// vector and random block streams with gaps, stalls and a chaining
// value change, and checks every digest against a reference model.
//----------------------------------------------------------------------
module sha256_pipe_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [255:0] INIT_HASH =
		256'h6a09e667_bb67ae85_3c6ef372_a54ff53a_510e527f_9b05688c_1f83d9ab_5be0cd19;
	localparam logic [255:0] ABC_DIGEST =
		256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad;
	localparam logic [511:0] ABC_BLOCK = {32'h61626380, {14{32'h00000000}}, 32'h00000018};
	localparam int TIMEOUT_CYCLES = 5000;

	logic               CLK;
	logic               RST;
	logic               en_i;
	logic               block_valid_i;
	sha256_pkg::block_t block_i;
	sha256_pkg::state_t chain_i;
	sha256_pkg::state_t digest_o;
	logic               digest_valid_o;

	integer         seed = 32'h2c30_5df8;
	logic [255:0]   expected_q [$];
	logic [255:0]   exp_digest;
	logic [255:0]   new_chain;
	logic [31:0]    r;
	logic           en_q = 1'b0;
	string          test_name = "reset";
	int             errors = 0;
	int             checked = 0;
	int             accepted = 0;
	int             cycles = 0;
	int             latency;

	sha256_pipe_top UUT (
		.CLK            (CLK),
		.RST            (RST),
		.en_i           (en_i),
		.block_valid_i  (block_valid_i),
		.block_i        (block_i),
		.chain_i        (chain_i),
		.digest_o       (digest_o),
		.digest_valid_o (digest_valid_o)
	);

	always #5 CLK = ~CLK;

	function automatic logic [31:0] rotate_right(input logic [31:0] x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// FIPS 180-4 compression of one block, chaining value added at the end
	function automatic logic [255:0] sha256_compress(input logic [511:0] blk,
			input logic [255:0] hv);
		logic [31:0]  w [0:63];
		logic [31:0]  v [0:7];
		logic [31:0]  s0;
		logic [31:0]  s1;
		logic [31:0]  t1;
		logic [31:0]  t2;
		logic [255:0] res;

		for (int i = 0; i < 16; i++) begin
			w[i] = blk[511 - 32*i -: 32];
		end
		for (int i = 16; i < 64; i++) begin
			s0 = rotate_right(w[i-15], 7) ^ rotate_right(w[i-15], 18) ^ (w[i-15] >> 3);
			s1 = rotate_right(w[i-2], 17) ^ rotate_right(w[i-2], 19) ^ (w[i-2] >> 10);
			w[i] = s1 + w[i-7] + s0 + w[i-16];
		end
		for (int i = 0; i < 8; i++) begin
			v[i] = hv[255 - 32*i -: 32];
		end
		for (int i = 0; i < 64; i++) begin
			t1 = v[7] + (rotate_right(v[4], 6) ^ rotate_right(v[4], 11)
				^ rotate_right(v[4], 25)) + ((v[4] & v[5]) ^ (~v[4] & v[6]))
				+ sha256_pkg::ROUND_K[i] + w[i];
			t2 = (rotate_right(v[0], 2) ^ rotate_right(v[0], 13)
				^ rotate_right(v[0], 22)) + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			for (int j = 7; j > 0; j--) begin
				v[j] = v[j-1];
			end
			v[4] = v[4] + t1;
			v[0] = t1 + t2;
		end
		for (int i = 0; i < 8; i++) begin
			res[255 - 32*i -: 32] = v[i] + hv[255 - 32*i -: 32];
		end
		return res;
	endfunction

	function automatic logic [511:0] random_block();
		logic [511:0] b;

		for (int i = 0; i < 16; i++) begin
			b[511 - 32*i -: 32] = $random(seed);
		end
		return b;
	endfunction

	function automatic logic [255:0] random_state();
		logic [255:0] s;

		for (int i = 0; i < 8; i++) begin
			s[255 - 32*i -: 32] = $random(seed);
		end
		return s;
	endfunction

	// One clock of stimulus; accepted blocks queue their expected digest
	task automatic drive(input logic en, input logic valid, input logic [511:0] blk);
		@(posedge CLK);
		en_i          <= en;
		block_valid_i <= valid;
		block_i       <= blk;
		if (en && valid) begin
			expected_q.push_back(sha256_compress(blk, chain_i));
			accepted++;
		end
	endtask

	task automatic drain_pipeline();
		int n;

		n = 0;
		while (expected_q.size() != 0 && n < 200) begin
			drive(1'b1, 1'b0, '0);
			n++;
		end
		if (expected_q.size() != 0) begin
			$display("ERROR: %0d digests never came out in test %s", expected_q.size(),
				test_name);
			errors++;
			expected_q.delete();
		end
	endtask

	always @(posedge CLK) begin
		en_q <= en_i;
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("ERROR: run stopped after %0d cycles without finishing", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// Outputs are settled by the falling edge
	always @(negedge CLK) begin
		if (RST && en_q && digest_valid_o) begin
			if (expected_q.size() == 0) begin
				$display("ERROR: digest arrived with no block outstanding in test %s", test_name);
				errors++;
			end else begin
				exp_digest = expected_q.pop_front();
				checked++;
				if (digest_o !== exp_digest) begin
					$display("CHECK FAILED %s: expected %h, actual %h", test_name, exp_digest,
						digest_o);
					errors++;
				end
			end
		end
	end

	initial begin
		CLK           = 1'b0;
		RST           = 1'b0;
		en_i          = 1'b0;
		block_valid_i = 1'b0;
		block_i       = '0;
		chain_i       = INIT_HASH;
		repeat (16) @(posedge CLK);
		RST <= 1'b1;

		test_name = "known_vector";
		if (sha256_compress(ABC_BLOCK, INIT_HASH) !== ABC_DIGEST) begin
			$display("CHECK FAILED %s: expected %h, actual %h", test_name, ABC_DIGEST,
				sha256_compress(ABC_BLOCK, INIT_HASH));
			errors++;
		end
		drive(1'b1, 1'b1, ABC_BLOCK);
		drive(1'b1, 1'b0, '0);
		latency = 1;
		@(negedge CLK);
		while (!digest_valid_o && latency < 100) begin
			drive(1'b1, 1'b0, '0);
			latency++;
			@(negedge CLK);
		end
		if (latency != 65) begin
			$display("CHECK FAILED %s latency: expected %0d, actual %0d", test_name, 65, latency);
			errors++;
		end
		drain_pipeline();

		test_name = "full_throughput";
		for (int i = 0; i < 200; i++) begin
			drive(1'b1, 1'b1, random_block());
		end
		drain_pipeline();

		test_name = "gaps";
		for (int i = 0; i < 150; i++) begin
			r = $random(seed);
			drive(1'b1, r[1:0] != 2'd0, random_block());
		end
		drain_pipeline();

		test_name = "stall";
		for (int i = 0; i < 150; i++) begin
			r = $random(seed);
			if (r[3:0] == 4'd0) begin
				repeat (r[6:4] + 1) drive(1'b0, r[7], random_block());
			end
			drive(1'b1, 1'b1, random_block());
		end
		drain_pipeline();

		test_name = "chain_change";
		new_chain = random_state();
		@(posedge CLK);
		chain_i <= new_chain;
		for (int i = 0; i < 100; i++) begin
			drive(1'b1, 1'b1, random_block());
		end
		drain_pipeline();

		if (checked != accepted) begin
			$display("ERROR: %0d blocks accepted but %0d digests checked", accepted, checked);
			errors++;
		end
		$display("Accepted %0d blocks, checked %0d digests, %0d errors", accepted, checked, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog/sha256_digest_add.sv ====
//----------------------------------------------------------------------
// Finisher stage. Adds the chaining value to the last working state
// word by word modulo 2^32 and registers the digest with its valid
// bit. Holds both outputs while en_i is low.
//----------------------------------------------------------------------
module sha256_digest_add (
	input  logic               CLK,
	input  logic               RST,
	input  logic               en_i,
	input  sha256_pkg::state_t final_state_i,
	input  logic               final_valid_i,
	input  sha256_pkg::state_t chain_i,
	output sha256_pkg::state_t digest_o,
	output logic               digest_valid_o
);

	sha256_pkg::state_t sum_d;

	// Eight independent 32-bit adds, no carry between words
	always_comb begin
		for (int i = 0; i < $bits(sha256_pkg::state_t) / $bits(sha256_pkg::word_t); i++) begin
			sum_d[i*$bits(sha256_pkg::word_t) +: $bits(sha256_pkg::word_t)] =
				final_state_i[i*$bits(sha256_pkg::word_t) +: $bits(sha256_pkg::word_t)] +
				chain_i[i*$bits(sha256_pkg::word_t) +: $bits(sha256_pkg::word_t)];
		end
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			digest_o       <= '0;
			digest_valid_o <= 1'b0;
		end else if (en_i) begin
			digest_o       <= sum_d;
			digest_valid_o <= final_valid_i;
		end
	end

endmodule

// ==== verilog/sha256_pipe_top.sv ====
//----------------------------------------------------------------------
// Fully pipelined SHA-256 compression core. Accepts one 512-bit block
// per enabled edge and returns its digest 65 enabled edges later.
// chain_i must stay constant while any block is in flight.
//----------------------------------------------------------------------
module sha256_pipe_top (
	input  logic               CLK,
	input  logic               RST,
	input  logic               en_i,
	input  logic               block_valid_i,
	input  sha256_pkg::block_t block_i,
	input  sha256_pkg::state_t chain_i,
	output sha256_pkg::state_t digest_o,
	output logic               digest_valid_o
);

	sha256_pkg::word_t  sched_words [0:sha256_pkg::NUM_ROUNDS-2];
	sha256_pkg::word_t  first_word;
	sha256_pkg::state_t final_state;
	logic               final_valid;

	// Round 0 uses W0 straight from the input
	assign first_word = block_i[$bits(sha256_pkg::block_t)-1 -: $bits(sha256_pkg::word_t)];

	sha256_msg_schedule u_msg_schedule (
		.CLK           (CLK),
		.RST           (RST),
		.en_i          (en_i),
		.block_i       (block_i),
		.sched_words_o (sched_words)
	);

	sha256_round_pipe u_round_pipe (
		.CLK           (CLK),
		.RST           (RST),
		.en_i          (en_i),
		.block_valid_i (block_valid_i),
		.first_word_i  (first_word),
		.chain_i       (chain_i),
		.sched_words_i (sched_words),
		.final_state_o (final_state),
		.final_valid_o (final_valid)
	);

	sha256_digest_add u_digest_add (
		.CLK            (CLK),
		.RST            (RST),
		.en_i           (en_i),
		.final_state_i  (final_state),
		.final_valid_i  (final_valid),
		.chain_i        (chain_i),
		.digest_o       (digest_o),
		.digest_valid_o (digest_valid_o)
	);

endmodule
